// ==== design/rp_analog_pkg.sv ====
package rp_analog_pkg;

  //////////////////////////////
  // Channel and width constants
  //////////////////////////////

  localparam int NUM_CH = 2;   // Two analog channels
  localparam int ADC_W  = 16;  // ADC converter resolution
  localparam int DAC_W  = 14;  // DAC converter resolution

  //////////////////////////////
  // Sample types
  //////////////////////////////

  // Two's complement samples inside the fabric
  typedef logic signed [ADC_W-1:0] adc_sample_t;
  typedef logic signed [DAC_W-1:0] dac_sample_t;

  // Pin codes, negative slope
  typedef logic [ADC_W-1:0] adc_raw_t;
  typedef logic [DAC_W-1:0] dac_code_t;

  // One guard bit for the generator + controller sum
  typedef logic signed [DAC_W:0] dac_sum_t;

endpackage : rp_analog_pkg

// ==== design/rp_sysbus_pkg.sv ====
package rp_sysbus_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////

  localparam int SYS_AW = 20;  // Byte address
  localparam int SYS_DW = 32;

  typedef logic [SYS_AW-1:0] sys_addr_t;
  typedef logic [SYS_DW-1:0] sys_data_t;

  //////////////////////////////
  // Housekeeping register map
  //////////////////////////////

  localparam sys_addr_t REG_ID  = 20'h0_0000;  // Read only
  localparam sys_addr_t REG_CFG = 20'h0_0004;  // Global config
  localparam sys_addr_t REG_LED = 20'h0_0030;  // LED pattern

  localparam sys_data_t HK_ID_VALUE  = 32'h5250_0001;
  localparam int        CFG_LOOP_BIT = 0;  // Digital loopback enable
  localparam int        LED_W        = 8;

endpackage : rp_sysbus_pkg

// ==== design/rp_sys_bus_if.sv ====
`timescale 1ns/10ps

interface rp_sys_bus_if;
  import rp_sysbus_pkg::*;

  sys_addr_t addr;   // Byte address
  sys_data_t wdata;  // Write data
  logic      wen;    // Write strobe, single cycle
  logic      ren;    // Read strobe, single cycle
  sys_data_t rdata;  // Valid with ack
  logic      err;    // Unmapped or read-only access
  logic      ack;    // One cycle after the request

  // Request side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, err, ack
  );

  // Register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, err, ack
  );

endinterface : rp_sys_bus_if

// ==== design/rp_hk_regs.sv ====
`timescale 1ns/10ps

module rp_hk_regs (
  input  logic                            adc_clk,    // ADC clock
  input  logic                            rst_i,      // Sync reset
  rp_sys_bus_if.slave                     bus,        // System bus
  output logic                            loop_en_o,  // Digital loopback
  output logic [rp_sysbus_pkg::LED_W-1:0] led_o       // LED pins
);
  import rp_sysbus_pkg::*;

  logic             hit_id;
  logic             hit_cfg;
  logic             hit_led;
  logic             addr_hit;  // Any mapped register
  logic             wr_ok;     // Writable register
  logic             cfg_loop;
  logic [LED_W-1:0] led_r;
  sys_data_t        rd_mux;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb
  begin
    hit_id   = (bus.addr == REG_ID);
    hit_cfg  = (bus.addr == REG_CFG);
    hit_led  = (bus.addr == REG_LED);
    addr_hit = hit_id | hit_cfg | hit_led;
    wr_ok    = hit_cfg | hit_led;  // ID is read only
  end

  // Read mux, unused bits read as zero
  always_comb
  begin
    rd_mux = '0;
    if (hit_id)
      rd_mux = HK_ID_VALUE;
    else if (hit_cfg)
      rd_mux[CFG_LOOP_BIT] = cfg_loop;
    else if (hit_led)
      rd_mux[LED_W-1:0] = led_r;
  end

  //////////////////////////////
  // Registers and handshake
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cfg_loop <= 1'b0;  // Loopback off
      led_r    <= '0;
      bus.ack  <= 1'b0;
      bus.err  <= 1'b0;
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;  // Answer next cycle
      bus.err <= (bus.wen & ~wr_ok) | (bus.ren & ~addr_hit);
      if (bus.wen && hit_cfg)
        cfg_loop <= bus.wdata[CFG_LOOP_BIT];
      if (bus.wen && hit_led)
        led_r <= bus.wdata[LED_W-1:0];
    end
  end

  // Read data captured with the request
  always_ff @(posedge adc_clk)
  begin
    if (bus.ren)
      bus.rdata <= rd_mux;
  end

  assign loop_en_o = cfg_loop;
  assign led_o     = led_r;

  // Master side must keep strobes exclusive
  a_one_strobe : assert property (@(posedge adc_clk) disable iff (rst_i)
    !(bus.wen && bus.ren));

  // Single-cycle ack, master waits for it before the next request
  a_ack_pulse : assert property (@(posedge adc_clk) disable iff (rst_i)
    bus.ack |=> !bus.ack);

endmodule : rp_hk_regs

// ==== design/rp_adc_frontend.sv ====
`timescale 1ns/10ps

module rp_adc_frontend (
  input  logic                                                     adc_clk,
  input  logic                                                     rst_i,
  input  rp_analog_pkg::adc_raw_t    [rp_analog_pkg::NUM_CH-1:0] adc_raw_i,  // Pin code
  input  logic                                                     loop_en_i,
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CH-1:0] dac_sat_i,  // From DAC path
  output rp_analog_pkg::adc_sample_t [rp_analog_pkg::NUM_CH-1:0] adc_dat_o
);
  import rp_analog_pkg::*;

  adc_raw_t    [NUM_CH-1:0] adc_raw_q;  // Input register
  adc_sample_t [NUM_CH-1:0] adc_conv;   // Two's complement
  adc_sample_t [NUM_CH-1:0] adc_next;   // Output register input

  //////////////////////////////
  // Input register
  //////////////////////////////

  // Sits close to the pins
  always_ff @(posedge adc_clk)
  begin
    adc_raw_q <= adc_raw_i;
  end

  // Negative slope to two's complement, loopback select
  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      adc_conv[ch] = {adc_raw_q[ch][ADC_W-1], ~adc_raw_q[ch][ADC_W-2:0]};  // Keep sign
      if (loop_en_i)
        // Sign extend the saturated DAC sample
        adc_next[ch] = {{(ADC_W-DAC_W){dac_sat_i[ch][DAC_W-1]}}, dac_sat_i[ch]};
      else
        adc_next[ch] = adc_conv[ch];
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      adc_dat_o <= '0;
    else
      adc_dat_o <= adc_next;  // Second stage of the ADC path
  end

  // Looped-back samples stay inside the 14-bit signed range
  for (genvar gc = 0; gc < NUM_CH; gc++)
  begin : g_chk
    a_loop_range : assert property (@(posedge adc_clk) disable iff (rst_i)
      $past(loop_en_i) |-> (($signed(adc_dat_o[gc]) >= -(2 ** (DAC_W - 1)))
                         && ($signed(adc_dat_o[gc]) < (2 ** (DAC_W - 1)))));
  end

endmodule : rp_adc_frontend

// ==== design/rp_dac_backend.sv ====
`timescale 1ns/10ps

module rp_dac_backend (
  input  logic                                                     adc_clk,
  input  logic                                                     rst_i,
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CH-1:0] gen_dat_i,   // Generator
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CH-1:0] ctrl_dat_i,  // Controller
  output rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CH-1:0] dac_sat_o,   // Combinational
  output rp_analog_pkg::dac_code_t   [rp_analog_pkg::NUM_CH-1:0] dac_code_o   // Pin code
);
  import rp_analog_pkg::*;

  dac_sum_t    [NUM_CH-1:0] dac_sum;
  logic        [NUM_CH-1:0] clamp;  // Sum out of 14-bit range
  dac_sample_t [NUM_CH-1:0] dac_sat;

  //////////////////////////////
  // Sum and saturation
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      // Sign extend both operands by one bit
      dac_sum[ch] = {gen_dat_i[ch][DAC_W-1], gen_dat_i[ch]}
                  + {ctrl_dat_i[ch][DAC_W-1], ctrl_dat_i[ch]};
      clamp[ch]   = dac_sum[ch][DAC_W] ^ dac_sum[ch][DAC_W-1];  // Top bits differ
      if (clamp[ch])
        // Max for positive overflow, min for negative
        dac_sat[ch] = {dac_sum[ch][DAC_W], {(DAC_W-1){~dac_sum[ch][DAC_W]}}};
      else
        dac_sat[ch] = dac_sum[ch][DAC_W-1:0];
    end
  end

  assign dac_sat_o = dac_sat;  // Also feeds ADC loopback

  //////////////////////////////
  // Output code register
  //////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        dac_code_o[ch] <= {1'b0, {(DAC_W-1){1'b1}}};  // Code for zero
    end
    else
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        dac_code_o[ch] <= {dac_sat[ch][DAC_W-1], ~dac_sat[ch][DAC_W-2:0]};
    end
  end

  // Clamping only on a true overflow of the 14-bit range
  for (genvar gc = 0; gc < NUM_CH; gc++)
  begin : g_chk
    a_clamp_range : assert property (@(posedge adc_clk) disable iff (rst_i)
      clamp[gc] |-> !(($signed(dac_sum[gc]) >= -(2 ** (DAC_W - 1)))
                   && ($signed(dac_sum[gc]) < (2 ** (DAC_W - 1)))));
  end

endmodule : rp_dac_backend

// ==== design/rp_analog_top.sv ====
`timescale 1ns/10ps

module rp_analog_top (
  input  logic                                                     adc_clk,
  input  logic                                                     rst_i,
  // ADC
  input  rp_analog_pkg::adc_raw_t    [rp_analog_pkg::NUM_CH-1:0] adc_dat_i,   // Pin code
  output rp_analog_pkg::adc_sample_t [rp_analog_pkg::NUM_CH-1:0] adc_dat_o,   // Signed
  // DAC
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CH-1:0] gen_dat_i,
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CH-1:0] ctrl_dat_i,
  output rp_analog_pkg::dac_code_t   [rp_analog_pkg::NUM_CH-1:0] dac_dat_o,
  // System bus
  input  rp_sysbus_pkg::sys_addr_t                                 sys_addr_i,
  input  rp_sysbus_pkg::sys_data_t                                 sys_wdata_i,
  input  logic                                                     sys_wen_i,
  input  logic                                                     sys_ren_i,
  output rp_sysbus_pkg::sys_data_t                                 sys_rdata_o,
  output logic                                                     sys_err_o,
  output logic                                                     sys_ack_o,
  // LED
  output logic [rp_sysbus_pkg::LED_W-1:0]                          led_o
);
  import rp_analog_pkg::*;

  logic                     loop_en;  // Config to front end
  dac_sample_t [NUM_CH-1:0] dac_sat;  // Loopback samples

  //////////////////////////////
  // System bus
  //////////////////////////////

  rp_sys_bus_if sys_bus ();

  // Master side comes straight from the pins
  assign sys_bus.addr  = sys_addr_i;
  assign sys_bus.wdata = sys_wdata_i;
  assign sys_bus.wen   = sys_wen_i;
  assign sys_bus.ren   = sys_ren_i;
  assign sys_rdata_o   = sys_bus.rdata;
  assign sys_err_o     = sys_bus.err;
  assign sys_ack_o     = sys_bus.ack;

  rp_hk_regs u_hk (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i  ),
    .bus       (sys_bus),
    .loop_en_o (loop_en),
    .led_o     (led_o  )
  );

  //////////////////////////////
  // Converters
  //////////////////////////////

  rp_adc_frontend u_adc (
    .adc_clk   (adc_clk  ),
    .rst_i     (rst_i    ),
    .adc_raw_i (adc_dat_i),
    .loop_en_i (loop_en  ),
    .dac_sat_i (dac_sat  ),  // Loopback source
    .adc_dat_o (adc_dat_o)
  );

  rp_dac_backend u_dac (
    .adc_clk    (adc_clk   ),  // DAC runs on the ADC clock
    .rst_i      (rst_i     ),
    .gen_dat_i  (gen_dat_i ),
    .ctrl_dat_i (ctrl_dat_i),
    .dac_sat_o  (dac_sat   ),
    .dac_code_o (dac_dat_o )
  );

endmodule : rp_analog_top

// ==== testbench/rp_analog_tb.sv ====
`timescale 1ns/10ps

module rp_analog_tb;
  import rp_analog_pkg::*;
  import rp_sysbus_pkg::*;

  localparam int unsigned SEED    = 32'h44db_ab56;
  localparam int          ACK_MAX = 10;  // Bus wait limit, cycles

  typedef adc_sample_t [NUM_CH-1:0] adc_vec_t;

  logic                     adc_clk = 1'b0;
  logic                     rst_i;
  adc_raw_t    [NUM_CH-1:0] adc_dat_i;
  adc_sample_t [NUM_CH-1:0] adc_dat_o;
  dac_sample_t [NUM_CH-1:0] gen_dat_i;
  dac_sample_t [NUM_CH-1:0] ctrl_dat_i;
  dac_code_t   [NUM_CH-1:0] dac_dat_o;
  sys_addr_t                sys_addr_i;
  sys_data_t                sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  sys_data_t                sys_rdata_o;
  logic                     sys_err_o;
  logic                     sys_ack_o;
  logic [LED_W-1:0]         led_o;

  int               errors   = 0;
  int               checks   = 0;
  int               tests    = 0;
  int               test_err = 0;  // Error count at start of current test
  logic             cfg_shadow;    // Register model
  logic [LED_W-1:0] led_shadow;
  adc_raw_t         corner [4] = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF};

  rp_analog_top u_dut (.*);

  always #20 adc_clk = ~adc_clk;  // 40 ns period

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Sign kept, lower 15 bits inverted
  function automatic adc_sample_t adc_model(input adc_raw_t raw);
    return raw ^ 16'h7FFF;
  endfunction

  // Generator + controller, clamped to the 14-bit range
  function automatic int sat_model(input dac_sample_t g, input dac_sample_t c);
    int s;
    s = int'(g) + int'(c);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act)
    else
    begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %-18s done, %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  // One request, then poll ack on falling edges
  task automatic bus_access(input logic wr, input sys_addr_t a, input sys_data_t d,
                            output sys_data_t rd, output logic er);
    int   n;
    logic got;
    got = 1'b0;
    n   = 0;
    rd  = '0;
    er  = 1'b0;
    @(negedge adc_clk);
    sys_addr_i  = a;
    sys_wdata_i = d;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    while (!got && n < ACK_MAX)
    begin
      @(negedge adc_clk);
      sys_wen_i = 1'b0;  // Single-cycle strobe
      sys_ren_i = 1'b0;
      if (sys_ack_o)
      begin
        got = 1'b1;
        rd  = sys_rdata_o;
        er  = sys_err_o;
      end
      n++;
    end
    if (!got)
    begin
      $display("Bus timeout, no ack within %0d cycles for address %h", ACK_MAX, a);
      errors++;
    end
  endtask

  task automatic write_reg(input string name, input sys_addr_t a, input sys_data_t d,
                           input logic exp_err);
    sys_data_t rd;
    logic      er;
    bus_access(1'b1, a, d, rd, er);
    check_eq({name, " err"}, exp_err, er);
  endtask

  task automatic read_reg(input string name, input sys_addr_t a, input sys_data_t exp,
                          input logic exp_err);
    sys_data_t rd;
    logic      er;
    bus_access(1'b0, a, '0, rd, er);
    check_eq({name, " err"}, exp_err, er);
    if (!exp_err)
      check_eq(name, exp, rd);
  endtask

  // Two-stage ADC path, expected values wait in a queue
  task automatic run_adc(input string name, input int n);
    adc_vec_t    exp_q[$];
    adc_vec_t    exp_v;
    logic [31:0] r;
    for (int i = 0; i < n + 2; i++)
    begin
      @(negedge adc_clk);
      if (i >= 2)
      begin
        exp_v = exp_q.pop_front();
        for (int ch = 0; ch < NUM_CH; ch++)
          check_eq($sformatf("%s ch%0d", name, ch), $unsigned(exp_v[ch]),
                   $unsigned(adc_dat_o[ch]));
      end
      if (i < n)
      begin
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
          r             = $urandom;
          adc_dat_i[ch] = (i < 4) ? corner[i] : r[15:0];  // Corners first
          exp_v[ch]     = adc_model(adc_dat_i[ch]);
        end
        exp_q.push_back(exp_v);
      end
    end
  endtask

  // One-cycle DAC path, and the ADC output too when looped back
  task automatic run_dac(input string name, input int n, input logic loop);
    int          exp_s [NUM_CH];
    logic [31:0] rg;
    logic [31:0] rc;
    for (int i = 0; i < n + 1; i++)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < NUM_CH && i > 0; ch++)
      begin
        check_eq($sformatf("%s dac ch%0d", name, ch), exp_s[ch][13:0] ^ 14'h1FFF,
                 dac_dat_o[ch]);
        if (loop)
          check_eq($sformatf("%s adc ch%0d", name, ch), exp_s[ch][15:0],
                   $unsigned(adc_dat_o[ch]));  // Sign extended
      end
      for (int ch = 0; ch < NUM_CH && i < n; ch++)
      begin
        rg             = $urandom;
        rc             = $urandom;
        gen_dat_i[ch]  = (i == 0) ? 14'h1FFF : (i == 1) ? 14'h2000 : rg[13:0];
        ctrl_dat_i[ch] = (i == 0) ? 14'h1FFF : (i == 1) ? 14'h2000 : rc[13:0];
        exp_s[ch]      = sat_model(gen_dat_i[ch], ctrl_dat_i[ch]);
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    logic [31:0] wval;
    void'($urandom(SEED));
    rst_i       = 1'b1;
    adc_dat_i   = '0;
    gen_dat_i   = '0;
    ctrl_dat_i  = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    cfg_shadow  = 1'b0;
    led_shadow  = '0;
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_i = 1'b0;  // Outputs still hold reset values here

    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      check_eq("reset adc", 32'h0, $unsigned(adc_dat_o[ch]));
      check_eq("reset dac", 32'h1FFF, dac_dat_o[ch]);  // Code for zero
    end
    check_eq("reset ack", 32'h0, sys_ack_o);
    check_eq("reset err", 32'h0, sys_err_o);
    check_eq("reset led", 32'h0, led_o);
    read_reg("reset cfg", REG_CFG, 32'h0, 1'b0);  // Loopback off
    finish_test("reset_values");

    run_adc("adc_conversion", 200);
    finish_test("adc_conversion");

    run_dac("dac_saturation", 200, 1'b0);
    finish_test("dac_saturation");

    read_reg("reg_access id", REG_ID, HK_ID_VALUE, 1'b0);
    repeat (8)
    begin
      wval = $urandom;
      write_reg("reg_access led write", REG_LED, wval, 1'b0);
      led_shadow = wval[LED_W-1:0];
      read_reg("reg_access led read", REG_LED, sys_data_t'(led_shadow), 1'b0);
      check_eq("reg_access led pins", led_shadow, led_o);
    end
    for (int k = 1; k >= 0; k--)
    begin
      wval               = $urandom;
      wval[CFG_LOOP_BIT] = k[0];  // Ends with loopback off
      write_reg("reg_access cfg write", REG_CFG, wval, 1'b0);
      cfg_shadow = wval[CFG_LOOP_BIT];
      read_reg("reg_access cfg read", REG_CFG, sys_data_t'(cfg_shadow), 1'b0);
    end
    finish_test("register_access");

    write_reg("bus_error wr unmapped", 20'h0_0008, $urandom, 1'b1);
    read_reg("bus_error rd unmapped", 20'h0_0010, '0, 1'b1);
    write_reg("bus_error wr id", REG_ID, $urandom, 1'b1);
    read_reg("bus_error id", REG_ID, HK_ID_VALUE, 1'b0);
    read_reg("bus_error cfg", REG_CFG, sys_data_t'(cfg_shadow), 1'b0);
    read_reg("bus_error led", REG_LED, sys_data_t'(led_shadow), 1'b0);
    check_eq("bus_error led pins", led_shadow, led_o);
    finish_test("bus_errors");

    write_reg("loopback on", REG_CFG, 32'h1, 1'b0);
    cfg_shadow = 1'b1;
    run_dac("loopback", 50, 1'b1);
    write_reg("loopback off", REG_CFG, 32'h0, 1'b0);
    cfg_shadow = 1'b0;
    repeat (2) @(negedge adc_clk);
    run_adc("loopback restored", 20);
    finish_test("digital_loopback");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule : rp_analog_tb

// ==== vlog.f ====
design/rp_analog_pkg.sv
design/rp_sysbus_pkg.sv
design/rp_sys_bus_if.sv
design/rp_hk_regs.sv
design/rp_adc_frontend.sv
design/rp_dac_backend.sv
design/rp_analog_top.sv
testbench/rp_analog_tb.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = rp_analog_tb
FLIST = vlog.f
OBJ   = obj_dir
BIN   = $(OBJ)/V$(TOP)
PASS  = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# Exit status comes from grep: nonzero unless the pass line was printed
run: compile
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ)
